//--- compile.f
src/rtc_pkg.sv
src/rtc_tick_gen.sv
src/rtc_second_fsm.sv
src/rtc_calendar.sv
src/rtc_alarm.sv
src/rtc_ctrl.sv
src/rtc_top.sv
test/tb_rtc.sv

//--- run.sh
#!/bin/sh
# Builds the RTC testbench with Verilator, runs it and scans the log for the fail message.
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -f compile.f --top-module tb_rtc \
    --Mdir obj_dir -o tb_rtc_sim > build.log 2>&1 \
    && ./obj_dir/tb_rtc_sim > sim.log 2>&1 \
    || { echo "Build or simulation did not complete"; cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -qF "*** TEST FAILED ***" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -qF "*** TEST PASSED ***" sim.log || { echo "No pass message found in sim.log"; exit 1; }
exit 0

//--- src/rtc_alarm.sv
// RTC alarm: stores the alarm time and matches it against the time of the coming update.
`timescale 1ns/100ps
`default_nettype none

module rtc_alarm import rtc_pkg::*; (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         reg_write_t host_wr,
    input  wire         rtc_time_t time_next,
    output logic        alarm_match,
    output logic [23:0] alarm_regs
);

    logic [7:0] alarm_second;
    logic [7:0] alarm_minute;
    logic [7:0] alarm_hour;

    function automatic logic field_match(input logic [7:0] alarm, input logic [7:0] value);
        field_match = (alarm[7:6] == alarm_dont_care) || (alarm == value);
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            alarm_second <= 8'd0;
            alarm_minute <= 8'd0;
            alarm_hour   <= 8'd0;
        end else if (host_wr.valid) begin
            case (host_wr.index)
                reg_alarm_second: alarm_second <= host_wr.data;
                reg_alarm_minute: alarm_minute <= host_wr.data;
                reg_alarm_hour:   alarm_hour   <= host_wr.data;
                default:          ;
            endcase
        end
    end

    // Comparing against the next time lets the flag set on the update edge itself.
    assign alarm_match = field_match(alarm_second, time_next.second) &&
                         field_match(alarm_minute, time_next.minute) &&
                         field_match(alarm_hour, time_next.hour);

    assign alarm_regs = {alarm_hour, alarm_minute, alarm_second};

endmodule

`default_nettype wire

//--- src/rtc_calendar.sv
// RTC calendar: time registers, host writes and the binary carry chain through the year.
`timescale 1ns/100ps
`default_nettype none

module rtc_calendar import rtc_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        second_start,
    input  wire        reg_write_t host_wr,
    output rtc_time_t  time_now,
    output rtc_time_t  time_next
);

    logic max_second;
    logic max_minute;
    logic max_hour;
    logic max_day_of_week;
    logic max_day_of_month;
    logic max_month;
    logic max_year;
    logic leap_year;
    logic carry_minute;
    logic carry_hour;
    logic carry_day;
    logic carry_month;
    logic carry_year;
    logic sec_wr;

    function automatic logic [7:0] month_days(input logic [7:0] month, input logic leap);
        case (month)
            8'd2:                    month_days = leap ? 8'd29 : 8'd28;
            8'd4, 8'd6, 8'd9, 8'd11: month_days = 8'd30;
            default:                 month_days = 8'd31;
        endcase
    endfunction

    // Every year divisible by four is a leap year over the 00..99 range.
    assign leap_year = (time_now.year[1:0] == 2'b00);

    // Wrap conditions use >= so that an out-of-range host value recovers on the next carry.
    assign max_second       = (time_now.second >= 8'd59);
    assign max_minute       = (time_now.minute >= 8'd59);
    assign max_hour         = (time_now.hour >= 8'd23);
    assign max_day_of_week  = (time_now.day_of_week >= 8'd7);
    assign max_day_of_month = (time_now.day_of_month >= month_days(time_now.month, leap_year));
    assign max_month        = (time_now.month >= 8'd12);
    assign max_year         = (time_now.year >= 8'd99);

    // A field advances only when every field below it wraps.
    assign carry_minute = max_second;
    assign carry_hour   = carry_minute && max_minute;
    assign carry_day    = carry_hour && max_hour;
    assign carry_month  = carry_day && max_day_of_month;
    assign carry_year   = carry_month && max_month;

    always_comb begin
        time_next = time_now;
        time_next.second = max_second ? 8'd0 : time_now.second + 8'd1;
        if (carry_minute) begin
            time_next.minute = max_minute ? 8'd0 : time_now.minute + 8'd1;
        end
        if (carry_hour) begin
            time_next.hour = max_hour ? 8'd0 : time_now.hour + 8'd1;
        end
        if (carry_day) begin
            time_next.day_of_week  = max_day_of_week ? 8'd1 : time_now.day_of_week + 8'd1;
            time_next.day_of_month = max_day_of_month ? 8'd1 : time_now.day_of_month + 8'd1;
        end
        if (carry_month) begin
            time_next.month = max_month ? 8'd1 : time_now.month + 8'd1;
        end
        if (carry_year) begin
            time_next.year = max_year ? 8'd0 : time_now.year + 8'd1;
        end
    end

    assign sec_wr = host_wr.valid && (host_wr.index == reg_second);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            time_now <= '{second: 8'd0, minute: 8'd0, hour: 8'd0, day_of_week: 8'd1,
                          day_of_month: 8'd1, month: 8'd1, year: 8'd0};
        end else begin
            if (second_start) begin
                time_now <= time_next;
            end
            // The host write comes last so it wins over a same-cycle update.
            if (host_wr.valid) begin
                case (host_wr.index)
                    reg_second:       time_now.second       <= host_wr.data;
                    reg_minute:       time_now.minute       <= host_wr.data;
                    reg_hour:         time_now.hour         <= host_wr.data;
                    reg_day_of_week:  time_now.day_of_week  <= host_wr.data;
                    reg_day_of_month: time_now.day_of_month <= host_wr.data;
                    reg_month:        time_now.month        <= host_wr.data;
                    reg_year:         time_now.year         <= host_wr.data;
                    default:          ;
                endcase
            end
        end
    end

    second_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        (time_now.second < 8'd60) && !sec_wr |=> (time_now.second < 8'd60)
    );

endmodule

`default_nettype wire

//--- src/rtc_ctrl.sv
// RTC control: index/data port decode, registers A to D, status flags and the interrupt.
`timescale 1ns/100ps
`default_nettype none

module rtc_ctrl import rtc_pkg::*; (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         addr,
    input  wire         read,
    input  wire         write,
    input  wire  [7:0]  wdata,
    input  wire         second_start,
    input  wire         uip,
    input  wire         alarm_match,
    input  wire         rtc_time_t time_now,
    input  wire  [23:0] alarm_regs,
    output logic [7:0]  rdata,
    output logic        irq,
    output logic        halt,
    output reg_write_t  host_wr
);

    logic       read_last;
    logic       read_first;
    logic       c_read;
    logic [6:0] index;
    logic [2:0] divider;
    logic       freeze;
    logic       alarm_en;
    logic       update_en;
    logic       update_flag;
    logic       alarm_flag;
    logic       irq_set;
    logic [7:0] rdata_next;

    // Side effects of a read happen only on its first cycle.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            read_last <= 1'b0;
        end else begin
            read_last <= read;
        end
    end

    assign read_first = read && !read_last;
    assign c_read     = read_first && addr && (index == reg_c);

    assign host_wr = '{valid: write && addr, index: index, data: wdata};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            index     <= 7'd0;
            divider   <= 3'b010;
            freeze    <= 1'b0;
            alarm_en  <= 1'b0;
            update_en <= 1'b0;
        end else if (write && !addr) begin
            index <= wdata[6:0];
        end else if (host_wr.valid && index == reg_a) begin
            divider <= wdata[6:4];
        end else if (host_wr.valid && index == reg_b) begin
            freeze    <= wdata[reg_b_freeze_bit];
            alarm_en  <= wdata[reg_b_alarm_en_bit];
            // Setting freeze also turns the update interrupt off.
            update_en <= wdata[reg_b_update_en_bit] && !wdata[reg_b_freeze_bit];
        end
    end

    assign halt    = freeze || (divider[2:1] == 2'b11);
    assign irq_set = (alarm_en && alarm_flag) || (update_en && update_flag);

    // Reading register C clears everything, and the clear beats a same-cycle set.
    always_ff @(posedge clk) begin
        if (!rst_n || c_read) begin
            update_flag <= 1'b0;
            alarm_flag  <= 1'b0;
            irq         <= 1'b0;
        end else begin
            if (second_start) begin
                update_flag <= 1'b1;
            end
            if (second_start && alarm_match) begin
                alarm_flag <= 1'b1;
            end
            if (irq_set) begin
                irq <= 1'b1;
            end
        end
    end

    always_comb begin
        rdata_next = 8'h00;
        if (!addr) begin
            rdata_next = 8'hFF;
        end else begin
            case (index)
                reg_second:       rdata_next = time_now.second;
                reg_alarm_second: rdata_next = alarm_regs[7:0];
                reg_minute:       rdata_next = time_now.minute;
                reg_alarm_minute: rdata_next = alarm_regs[15:8];
                reg_hour:         rdata_next = time_now.hour;
                reg_alarm_hour:   rdata_next = alarm_regs[23:16];
                reg_day_of_week:  rdata_next = time_now.day_of_week;
                reg_day_of_month: rdata_next = time_now.day_of_month;
                reg_month:        rdata_next = time_now.month;
                reg_year:         rdata_next = time_now.year;
                reg_a:            rdata_next = {uip, divider, 4'b0000};
                // Binary and 24-hour mode are fixed, so bits 2 and 1 always read 1.
                reg_b:            rdata_next = {freeze, 1'b0, alarm_en, update_en, 4'b0110};
                reg_c:            rdata_next = {irq, 1'b0, alarm_flag, update_flag, 4'b0000};
                reg_d:            rdata_next = reg_d_value;
                default:          rdata_next = 8'h00;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        rdata <= rdata_next;
    end

    irq_needs_enabled_flag: assert property (
        @(posedge clk) disable iff (!rst_n) $rose(irq) |-> $past(irq_set)
    );

endmodule

`default_nettype wire

//--- src/rtc_pkg.sv
// RTC package: register indices, tick constants, register B bit positions and shared structs.
`default_nettype none

package rtc_pkg;

    // Register indices on the index/data port.
    localparam logic [6:0] reg_second       = 7'h00;
    localparam logic [6:0] reg_alarm_second = 7'h01;
    localparam logic [6:0] reg_minute       = 7'h02;
    localparam logic [6:0] reg_alarm_minute = 7'h03;
    localparam logic [6:0] reg_hour         = 7'h04;
    localparam logic [6:0] reg_alarm_hour   = 7'h05;
    localparam logic [6:0] reg_day_of_week  = 7'h06;
    localparam logic [6:0] reg_day_of_month = 7'h07;
    localparam logic [6:0] reg_month        = 7'h08;
    localparam logic [6:0] reg_year         = 7'h09;
    localparam logic [6:0] reg_a            = 7'h0A;
    localparam logic [6:0] reg_b            = 7'h0B;
    localparam logic [6:0] reg_c            = 7'h0C;
    localparam logic [6:0] reg_d            = 7'h0D;

    // Timebase. The second machine runs from an 800 Hz tick.
    localparam int unsigned tick_hz          = 800;
    localparam int unsigned ticks_per_second = 800;
    localparam int unsigned uip_ticks        = 2;

    // Top two bits of an alarm byte that mark the field as don't care.
    localparam logic [1:0] alarm_dont_care = 2'b11;

    // Register D always reports valid RAM and time.
    localparam logic [7:0] reg_d_value = 8'h80;

    // Writable bit positions in register B.
    localparam int unsigned reg_b_freeze_bit    = 7;
    localparam int unsigned reg_b_alarm_en_bit  = 5;
    localparam int unsigned reg_b_update_en_bit = 4;

    typedef struct packed {
        logic [7:0] second;
        logic [7:0] minute;
        logic [7:0] hour;
        logic [7:0] day_of_week;
        logic [7:0] day_of_month;
        logic [7:0] month;
        logic [7:0] year;
    } rtc_time_t;

    typedef struct packed {
        logic       valid;
        logic [6:0] index;
        logic [7:0] data;
    } reg_write_t;

endpackage

`default_nettype wire

//--- src/rtc_second_fsm.sv
// RTC second FSM: paces one update per second and flags the update-in-progress window.
`timescale 1ns/100ps
`default_nettype none

module rtc_second_fsm import rtc_pkg::*; (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  tick,
    input  wire  halt,
    output logic second_start,
    output logic uip
);

    typedef enum logic [2:0] {
        st_update_start,
        st_update_in_progress,
        st_second_start,
        st_second_in_progress,
        st_stopped
    } sec_state_t;

    sec_state_t  state;
    logic [10:0] countdown;

    always_ff @(posedge clk) begin
        if (!rst_n || halt) begin
            // A restart waits a full second plus a few ticks before the first update.
            state     <= st_stopped;
            countdown <= 11'(ticks_per_second + 4);
        end else begin
            if (tick) begin
                countdown <= (countdown == '0) ? 11'(ticks_per_second - 1) : countdown - 11'd1;
            end

            case (state)
                st_stopped:            state <= st_second_in_progress;
                st_second_in_progress: begin
                    if (countdown == 11'(uip_ticks)) begin
                        state <= st_update_start;
                    end
                end
                st_update_start:       state <= st_update_in_progress;
                st_update_in_progress: begin
                    if (countdown == '0) begin
                        state <= st_second_start;
                    end
                end
                st_second_start:       state <= st_second_in_progress;
                default:               state <= st_stopped;
            endcase
        end
    end

    assign second_start = (state == st_second_start);

    // UIP covers the last ticks before the update and the update cycle itself.
    assign uip = (state == st_update_in_progress) || (state == st_second_start);

    second_start_single: assert property (
        @(posedge clk) disable iff (!rst_n) second_start |=> !second_start
    );

endmodule

`default_nettype wire

//--- src/rtc_tick_gen.sv
// RTC tick generator: fractional accumulator that turns the system clock into an 800 Hz strobe.
`timescale 1ns/100ps
`default_nettype none

module rtc_tick_gen import rtc_pkg::*; #(
    parameter int unsigned clk_hz = 50_000_000
) (
    input  wire  clk,
    input  wire  rst_n,
    output logic tick
);

    logic [31:0] acc;
    logic [32:0] sum;

    // One extra bit keeps the sum from wrapping for any 32-bit clock rate.
    assign sum = {1'b0, acc} + 33'(tick_hz);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc  <= '0;
            tick <= 1'b0;
        end else if (sum >= 33'(clk_hz)) begin
            // The remainder carries over, so the average rate is exact.
            acc  <= 32'(sum - 33'(clk_hz));
            tick <= 1'b1;
        end else begin
            acc  <= sum[31:0];
            tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- src/rtc_top.sv
// RTC top level: connects the port controller to the tick, second, calendar and alarm blocks.
`timescale 1ns/100ps
`default_nettype none

module rtc_top import rtc_pkg::*; #(
    parameter int unsigned clk_hz = 50_000_000
) (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        addr,
    input  wire        read,
    input  wire        write,
    input  wire  [7:0] wdata,
    output logic       irq,
    output logic [7:0] rdata
);

    logic        tick;
    logic        halt;
    logic        second_start;
    logic        uip;
    logic        alarm_match;
    logic [23:0] alarm_regs;
    reg_write_t  host_wr;
    rtc_time_t   time_now;
    rtc_time_t   time_next;

    rtc_ctrl rtc_ctrl_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .addr         (addr),
        .read         (read),
        .write        (write),
        .wdata        (wdata),
        .second_start (second_start),
        .uip          (uip),
        .alarm_match  (alarm_match),
        .time_now     (time_now),
        .alarm_regs   (alarm_regs),
        .rdata        (rdata),
        .irq          (irq),
        .halt         (halt),
        .host_wr      (host_wr)
    );

    rtc_tick_gen #(.clk_hz(clk_hz)) rtc_tick_gen_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .tick  (tick)
    );

    rtc_second_fsm rtc_second_fsm_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .tick         (tick),
        .halt         (halt),
        .second_start (second_start),
        .uip          (uip)
    );

    rtc_calendar rtc_calendar_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .second_start (second_start),
        .host_wr      (host_wr),
        .time_now     (time_now),
        .time_next    (time_next)
    );

    rtc_alarm rtc_alarm_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .host_wr     (host_wr),
        .time_next   (time_next),
        .alarm_match (alarm_match),
        .alarm_regs  (alarm_regs)
    );

endmodule

`default_nettype wire

//--- test/tb_rtc.sv
// Testbench for the RTC that walks the index/data port through reset, read back, rollover, alarm and halt.
`timescale 1ns/100ps
`default_nettype none

module tb_rtc import rtc_pkg::*; ();

    localparam int cycles_per_second = 8000;
    localparam int seconds_waited    = 12;
    localparam int halt_cycles       = 20000;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       addr;
    logic       read;
    logic       write;
    logic [7:0] wdata;
    logic       irq;
    logic [7:0] rdata;

    int pass_count;
    int fail_count;
    int test_errors;

    logic [6:0] reg_table_index [10];
    logic [7:0] reg_table_value [10];
    rtc_time_t  roll_start [4];
    rtc_time_t  roll_expect [4];

    rtc_top #(.clk_hz(8000)) rtc_top_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .addr  (addr),
        .read  (read),
        .write (write),
        .wdata (wdata),
        .irq   (irq),
        .rdata (rdata)
    );

    always #5 clk = ~clk;

    function automatic rtc_time_t build_time(input logic [7:0] sec, input logic [7:0] min,
                                             input logic [7:0] hr, input logic [7:0] dow,
                                             input logic [7:0] dom, input logic [7:0] mon,
                                             input logic [7:0] yr);
        build_time = '{second: sec, minute: min, hour: hr, day_of_week: dow,
                       day_of_month: dom, month: mon, year: yr};
    endfunction

    task automatic load_tables();
        reg_table_index = '{reg_second, reg_alarm_second, reg_minute, reg_alarm_minute,
                            reg_hour, reg_alarm_hour, reg_day_of_week, reg_day_of_month,
                            reg_month, reg_year};
        reg_table_value = '{8'h2A, 8'h15, 8'h0B, 8'hC0, 8'h11, 8'h07, 8'h05, 8'h1C,
                            8'h09, 8'h42};
        // Leap February, plain February, end of century and a 30-day month.
        roll_start[0]  = build_time(8'd59, 8'd59, 8'd23, 8'd7, 8'd28, 8'd2, 8'd4);
        roll_expect[0] = build_time(8'd0, 8'd0, 8'd0, 8'd1, 8'd29, 8'd2, 8'd4);
        roll_start[1]  = build_time(8'd59, 8'd59, 8'd23, 8'd3, 8'd28, 8'd2, 8'd3);
        roll_expect[1] = build_time(8'd0, 8'd0, 8'd0, 8'd4, 8'd1, 8'd3, 8'd3);
        roll_start[2]  = build_time(8'd59, 8'd59, 8'd23, 8'd1, 8'd31, 8'd12, 8'd99);
        roll_expect[2] = build_time(8'd0, 8'd0, 8'd0, 8'd2, 8'd1, 8'd1, 8'd0);
        roll_start[3]  = build_time(8'd59, 8'd59, 8'd23, 8'd2, 8'd30, 8'd4, 8'd10);
        roll_expect[3] = build_time(8'd0, 8'd0, 8'd0, 8'd3, 8'd1, 8'd5, 8'd10);
    endtask

    task automatic check(input logic [7:0] actual, input logic [7:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("ERR %0t: %s read 0x%02h, expected 0x%02h", $time, what, actual, expected);
            fail_count++;
            test_errors++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %s finished with %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    task automatic bus_write(input logic port, input logic [7:0] data);
        @(posedge clk);
        addr  <= port;
        wdata <= data;
        write <= 1'b1;
        @(posedge clk);
        write <= 1'b0;
    endtask

    // The read data is registered, so it is taken at the falling edge after the access.
    task automatic bus_read(input logic port, output logic [7:0] data);
        @(posedge clk);
        addr <= port;
        read <= 1'b1;
        @(posedge clk);
        read <= 1'b0;
        @(negedge clk);
        data = rdata;
    endtask

    task automatic write_reg(input logic [6:0] index, input logic [7:0] data);
        bus_write(1'b0, {1'b0, index});
        bus_write(1'b1, data);
    endtask

    task automatic read_reg(input logic [6:0] index, output logic [7:0] data);
        bus_write(1'b0, {1'b0, index});
        bus_read(1'b1, data);
    endtask

    // A register C read during the update cycle would drop the flag, so the UIP window
    // in register A is allowed to pass before register C is polled.
    task automatic wait_update_window();
        logic [7:0] a_value;
        a_value = 8'h00;
        bus_write(1'b0, {1'b0, reg_a});
        while (a_value[7] == 1'b0) begin
            bus_read(1'b1, a_value);
        end
        while (a_value[7] == 1'b1) begin
            bus_read(1'b1, a_value);
        end
    endtask

    task automatic poll_update_flag(output logic [7:0] c_value);
        logic [7:0] value;
        value = 8'h00;
        bus_write(1'b0, {1'b0, reg_c});
        while (value[4] == 1'b0) begin
            bus_read(1'b1, value);
        end
        c_value = value;
    endtask

    task automatic wait_update(output logic [7:0] c_value);
        wait_update_window();
        poll_update_flag(c_value);
    endtask

    // Time fields go in while frozen, and stale flags are cleared before the restart.
    task automatic set_time(input rtc_time_t t, input logic [7:0] b_value);
        logic [7:0] dummy;
        write_reg(reg_b, 8'h80);
        write_reg(reg_second, t.second);
        write_reg(reg_minute, t.minute);
        write_reg(reg_hour, t.hour);
        write_reg(reg_day_of_week, t.day_of_week);
        write_reg(reg_day_of_month, t.day_of_month);
        write_reg(reg_month, t.month);
        write_reg(reg_year, t.year);
        read_reg(reg_c, dummy);
        write_reg(reg_b, b_value);
    endtask

    task automatic read_time(output rtc_time_t t);
        rtc_time_t value;
        read_reg(reg_second, value.second);
        read_reg(reg_minute, value.minute);
        read_reg(reg_hour, value.hour);
        read_reg(reg_day_of_week, value.day_of_week);
        read_reg(reg_day_of_month, value.day_of_month);
        read_reg(reg_month, value.month);
        read_reg(reg_year, value.year);
        t = value;
    endtask

    task automatic compare_time(input rtc_time_t actual, input rtc_time_t expected,
                                input int row);
        check(actual.second, expected.second, $sformatf("row %0d second", row));
        check(actual.minute, expected.minute, $sformatf("row %0d minute", row));
        check(actual.hour, expected.hour, $sformatf("row %0d hour", row));
        check(actual.day_of_week, expected.day_of_week, $sformatf("row %0d weekday", row));
        check(actual.day_of_month, expected.day_of_month, $sformatf("row %0d day", row));
        check(actual.month, expected.month, $sformatf("row %0d month", row));
        check(actual.year, expected.year, $sformatf("row %0d year", row));
    endtask

    initial begin : watchdog
        repeat ((seconds_waited + 4) * cycles_per_second) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles",
                 (seconds_waited + 4) * cycles_per_second);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin : main_sequence
        logic [7:0] value;
        logic [7:0] seconds_before;
        rtc_time_t  time_read;
        rtc_time_t  alarm_time;
        rst_n       <= 1'b0;
        addr        <= 1'b0;
        read        <= 1'b0;
        write       <= 1'b0;
        wdata       <= 8'h00;
        pass_count  = 0;
        fail_count  = 0;
        test_errors = 0;
        load_tables();
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        bus_read(1'b0, value);
        check(value, 8'hFF, "index port");
        read_reg(reg_d, value);
        check(value, 8'h80, "register D");
        read_reg(reg_b, value);
        check(value, 8'h06, "register B");
        read_reg(reg_a, value);
        check(value, 8'h20, "register A");
        // A register C read clears irq, so irq is looked at first.
        check({7'b0, irq}, 8'h00, "irq after reset");
        read_reg(reg_c, value);
        check(value, 8'h00, "register C");
        finish_test("reset values");

        write_reg(reg_b, 8'h80);
        for (int i = 0; i < 10; i++) begin
            write_reg(reg_table_index[i], reg_table_value[i]);
        end
        for (int i = 0; i < 10; i++) begin
            read_reg(reg_table_index[i], value);
            check(value, reg_table_value[i], $sformatf("index 0x%02h", reg_table_index[i]));
        end
        write_reg(reg_b, 8'h00);
        finish_test("register read back");

        for (int row = 0; row < 4; row++) begin
            set_time(roll_start[row], 8'h00);
            wait_update(value);
            read_time(time_read);
            compare_time(time_read, roll_expect[row], row);
        end
        finish_test("calendar rollover");

        // Seconds are don't care, so 10:20:31 after the update matches the alarm.
        alarm_time = build_time(8'd30, 8'd20, 8'd10, 8'd1, 8'd1, 8'd1, 8'd0);
        write_reg(reg_b, 8'h80);
        write_reg(reg_alarm_second, 8'hC0);
        write_reg(reg_alarm_minute, 8'd20);
        write_reg(reg_alarm_hour, 8'd10);
        set_time(alarm_time, 8'h20);
        wait_update_window();
        @(negedge clk);
        check({7'b0, irq}, 8'h01, "irq after alarm update");
        poll_update_flag(value);
        check(value, 8'hB0, "register C with alarm");
        check({7'b0, irq}, 8'h00, "irq after register C read");
        read_reg(reg_c, value);
        check(value, 8'h00, "register C second read");
        write_reg(reg_b, 8'h80);
        write_reg(reg_alarm_hour, 8'd11);
        set_time(alarm_time, 8'h20);
        wait_update_window();
        @(negedge clk);
        check({7'b0, irq}, 8'h00, "irq without alarm");
        poll_update_flag(value);
        check(value, 8'h10, "register C without alarm");
        finish_test("alarm interrupt");

        write_reg(reg_b, 8'h80);
        read_reg(reg_c, value);
        read_reg(reg_second, seconds_before);
        repeat (halt_cycles) @(posedge clk);
        read_reg(reg_second, value);
        check(value, seconds_before, "seconds while frozen");
        read_reg(reg_c, value);
        check(value & 8'h10, 8'h00, "update flag while frozen");

        // Divider 110 holds the chain in reset without freeze.
        write_reg(reg_b, 8'h00);
        write_reg(reg_a, 8'h60);
        read_reg(reg_a, value);
        check(value, 8'h60, "register A with divider 110");
        read_reg(reg_c, value);
        read_reg(reg_second, seconds_before);
        repeat (halt_cycles) @(posedge clk);
        read_reg(reg_second, value);
        check(value, seconds_before, "seconds with divider 110");
        read_reg(reg_c, value);
        check(value & 8'h10, 8'h00, "update flag with divider 110");

        write_reg(reg_a, 8'h20);
        wait_update(value);
        read_reg(reg_second, value);
        check(value, (seconds_before == 8'd59) ? 8'd0 : seconds_before + 8'd1,
              "seconds after restart");
        finish_test("halt");

        $display("checks passed: %0d, checks failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
